//--- logic/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int LINE_ADDR_BITS = 10;
    localparam int SET_BITS = 4;
    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int REQ_TAG_BITS = 6;

    // line address is {line tag, set index}
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [LINE_ADDR_BITS-SET_BITS-1:0] line_tag_t;

    // opaque core tag, returned with the response
    typedef logic [REQ_TAG_BITS-1:0] req_tag_t;

endpackage

`default_nettype wire

//--- logic/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    localparam int MRVQ_SIZE = 8;
    typedef logic [$clog2(MRVQ_SIZE)-1:0] mrvq_ptr_t;
    typedef logic [$clog2(MRVQ_SIZE):0] mrvq_count_t;

    // room for the requests still in st1 to st3
    localparam int FULL_DISTANCE = 3;

    localparam int PIPE_DEPTH = 3;
    localparam int REQ_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

//--- logic/core_req_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module core_req_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  cache_geom_pkg::line_addr_t push_addr,
    input  cache_geom_pkg::req_tag_t   push_tag,
    input  logic                       pop,
    output logic                       head_valid,
    output cache_geom_pkg::line_addr_t head_addr,
    output cache_geom_pkg::req_tag_t   head_tag,
    output logic                       full
);

    typedef logic [$clog2(DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(DEPTH):0] fifo_count_t;

    cache_geom_pkg::line_addr_t addr_mem [DEPTH];
    cache_geom_pkg::req_tag_t   tag_mem [DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;

    // head is visible without a read cycle
    assign head_valid = (count != '0);
    assign head_addr = addr_mem[rd_ptr];
    assign head_tag = tag_mem[rd_ptr];
    assign full = (count == fifo_count_t'(DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
            if (push && !pop) begin
                count <= count + fifo_count_t'(1);
            end else if (pop && !push) begin
                count <= count - fifo_count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= push_addr;
            tag_mem[wr_ptr] <= push_tag;
        end
    end

    // core side honours full, pipeline only pops a valid head
    assert property (@(posedge clk) disable iff (reset)
        !(push && full) && !(pop && !head_valid));

endmodule

`default_nettype wire

//--- logic/line_state_table.sv
`timescale 1ns/100ps
`default_nettype none

module line_state_table (
    input  logic                       clk,
    input  logic                       reset,
    input  cache_geom_pkg::line_addr_t lookup_addr,
    input  logic                       fill_valid,
    input  cache_geom_pkg::line_addr_t fill_addr,
    output logic                       lookup_hit
);

    logic [cache_geom_pkg::NUM_SETS-1:0] valid_bits;
    cache_geom_pkg::line_tag_t tag_mem [cache_geom_pkg::NUM_SETS];

    cache_geom_pkg::set_idx_t  lookup_set;
    cache_geom_pkg::set_idx_t  fill_set;
    cache_geom_pkg::line_tag_t lookup_tag;
    cache_geom_pkg::line_tag_t fill_tag;

    assign lookup_set = lookup_addr[cache_geom_pkg::SET_BITS-1:0];
    assign lookup_tag = lookup_addr[cache_geom_pkg::LINE_ADDR_BITS-1:cache_geom_pkg::SET_BITS];
    assign fill_set = fill_addr[cache_geom_pkg::SET_BITS-1:0];
    assign fill_tag = fill_addr[cache_geom_pkg::LINE_ADDR_BITS-1:cache_geom_pkg::SET_BITS];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            lookup_hit <= 1'b0;
        end else begin
            if (fill_valid) begin
                valid_bits[fill_set] <= 1'b1;
            end
            // lookup sees the array before this cycle's fill
            lookup_hit <= valid_bits[lookup_set] && (tag_mem[lookup_set] == lookup_tag);
        end
    end

    // direct mapped, newest fill owns the set
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[fill_set] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/miss_resrv_queue.sv
`timescale 1ns/100ps
`default_nettype none

module miss_resrv_queue (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enqueue_st3,
    input  cache_geom_pkg::line_addr_t enqueue_addr_st3,
    input  cache_geom_pkg::req_tag_t   enqueue_tag_st3,
    input  logic                       enqueue_msrq_st3,
    input  logic                       enqueue_ready_st3,
    output logic                       enqueue_full,
    output logic                       enqueue_almfull,
    input  logic                       update_ready_st0,
    input  cache_geom_pkg::line_addr_t addr_st0,
    output logic                       pending_hazard_st0,
    input  logic                       schedule_st0,
    output logic                       dequeue_valid_st0,
    output cache_geom_pkg::line_addr_t dequeue_addr_st0,
    output cache_geom_pkg::req_tag_t   dequeue_tag_st0,
    input  logic                       dequeue_st3
);

    cache_geom_pkg::line_addr_t addr_table [pipe_ctrl_pkg::MRVQ_SIZE];
    cache_geom_pkg::req_tag_t   tag_table [pipe_ctrl_pkg::MRVQ_SIZE];

    logic [pipe_ctrl_pkg::MRVQ_SIZE-1:0] valid_table;
    logic [pipe_ctrl_pkg::MRVQ_SIZE-1:0] ready_table;
    logic [pipe_ctrl_pkg::MRVQ_SIZE-1:0] addr_match;

    pipe_ctrl_pkg::mrvq_ptr_t   head_ptr;
    pipe_ctrl_pkg::mrvq_ptr_t   tail_ptr;
    pipe_ctrl_pkg::mrvq_ptr_t   schedule_ptr;
    pipe_ctrl_pkg::mrvq_ptr_t   restore_ptr;
    pipe_ctrl_pkg::mrvq_count_t size;

    logic push;

    assign push = enqueue_st3 && !enqueue_msrq_st3;

    assign enqueue_full = (size == pipe_ctrl_pkg::mrvq_count_t'(pipe_ctrl_pkg::MRVQ_SIZE));
    assign enqueue_almfull = (size >= pipe_ctrl_pkg::mrvq_count_t'(
        pipe_ctrl_pkg::MRVQ_SIZE - pipe_ctrl_pkg::FULL_DISTANCE));

    always_comb begin
        for (int i = 0; i < pipe_ctrl_pkg::MRVQ_SIZE; i++) begin
            addr_match[i] = valid_table[i] && (addr_table[i] == addr_st0);
        end
    end

    assign pending_hazard_st0 = |addr_match;

    // in-order replay from the schedule pointer
    assign dequeue_valid_st0 = valid_table[schedule_ptr] && ready_table[schedule_ptr];
    assign dequeue_addr_st0 = addr_table[schedule_ptr];
    assign dequeue_tag_st0 = tag_table[schedule_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_table <= '0;
            ready_table <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            schedule_ptr <= '0;
            restore_ptr <= '0;
            size <= '0;
        end else begin
            if (update_ready_st0) begin
                ready_table <= ready_table | addr_match;
            end

            if (enqueue_st3) begin
                if (enqueue_msrq_st3) begin
                    // replay missed again, park it and rewind
                    valid_table[restore_ptr] <= 1'b1;
                    ready_table[restore_ptr] <= enqueue_ready_st3;
                    schedule_ptr <= head_ptr;
                end else begin
                    valid_table[tail_ptr] <= 1'b1;
                    ready_table[tail_ptr] <= enqueue_ready_st3;
                    tail_ptr <= tail_ptr + pipe_ctrl_pkg::mrvq_ptr_t'(1);
                    size <= size + pipe_ctrl_pkg::mrvq_count_t'(1);
                end
            end else if (dequeue_st3) begin
                valid_table[head_ptr] <= 1'b0;
                head_ptr <= head_ptr + pipe_ctrl_pkg::mrvq_ptr_t'(1);
                size <= size - pipe_ctrl_pkg::mrvq_count_t'(1);
            end

            if (schedule_st0) begin
                valid_table[schedule_ptr] <= 1'b0;
                restore_ptr <= schedule_ptr;
                schedule_ptr <= schedule_ptr + pipe_ctrl_pkg::mrvq_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_table[tail_ptr] <= enqueue_addr_st3;
            tag_table[tail_ptr] <= enqueue_tag_st3;
        end
    end

    assert property (@(posedge clk) disable iff (reset) schedule_st0 |-> dequeue_valid_st0);

    // almost-full margin must cover everything already past st0
    assert property (@(posedge clk) disable iff (reset) push |-> !enqueue_full);

    assert property (@(posedge clk) disable iff (reset) !(enqueue_st3 && dequeue_st3));

endmodule

`default_nettype wire

//--- logic/bank_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module bank_pipeline (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fifo_valid,
    input  cache_geom_pkg::line_addr_t fifo_addr,
    input  cache_geom_pkg::req_tag_t   fifo_tag,
    output logic                       fifo_pop,
    input  logic                       fill_valid,
    input  cache_geom_pkg::line_addr_t fill_addr,
    output cache_geom_pkg::line_addr_t lookup_addr,
    input  logic                       lookup_hit,
    output cache_geom_pkg::line_addr_t addr_st0,
    output logic                       update_ready_st0,
    input  logic                       pending_hazard_st0,
    input  logic                       dequeue_valid_st0,
    input  cache_geom_pkg::line_addr_t dequeue_addr_st0,
    input  cache_geom_pkg::req_tag_t   dequeue_tag_st0,
    output logic                       schedule_st0,
    input  logic                       enqueue_almfull,
    output logic                       enqueue_st3,
    output cache_geom_pkg::line_addr_t enqueue_addr_st3,
    output cache_geom_pkg::req_tag_t   enqueue_tag_st3,
    output logic                       enqueue_msrq_st3,
    output logic                       enqueue_ready_st3,
    output logic                       dequeue_st3,
    output logic                       mem_req_valid,
    output cache_geom_pkg::line_addr_t mem_req_addr,
    output logic                       core_rsp_valid,
    output cache_geom_pkg::req_tag_t   core_rsp_tag,
    output cache_geom_pkg::line_addr_t core_rsp_addr
);

    // stage k of these vectors is st<k>
    logic [pipe_ctrl_pkg::PIPE_DEPTH:1] v_q;
    logic [pipe_ctrl_pkg::PIPE_DEPTH:1] fill_q;
    logic [pipe_ctrl_pkg::PIPE_DEPTH:1] rpl_q;
    logic [pipe_ctrl_pkg::PIPE_DEPTH:1] haz_q;
    logic [pipe_ctrl_pkg::PIPE_DEPTH:2] hit_q;
    logic [pipe_ctrl_pkg::PIPE_DEPTH:1] stage_hit;
    cache_geom_pkg::line_addr_t addr_q [1:pipe_ctrl_pkg::PIPE_DEPTH];
    cache_geom_pkg::req_tag_t   tag_q [1:pipe_ctrl_pkg::PIPE_DEPTH];

    logic do_replay;
    logic do_core;
    logic issue_st0;
    logic replay_inflight;
    logic inflight_miss;
    logic hazard_st0;
    logic fill_match_st3;
    logic at_st3;
    cache_geom_pkg::req_tag_t tag_st0;

    assign stage_hit = {hit_q, lookup_hit};

    // fill first, then one replay at a time, then new core requests
    assign replay_inflight = |(v_q & rpl_q);
    assign do_replay = !fill_valid && dequeue_valid_st0 && !replay_inflight;
    assign do_core = !fill_valid && !do_replay && fifo_valid && !enqueue_almfull;
    assign issue_st0 = fill_valid || do_replay || do_core;

    assign addr_st0 = fill_valid ? fill_addr : (do_replay ? dequeue_addr_st0 : fifo_addr);
    assign tag_st0 = do_replay ? dequeue_tag_st0 : fifo_tag;
    assign lookup_addr = addr_st0;
    assign update_ready_st0 = fill_valid;
    assign schedule_st0 = do_replay;
    assign fifo_pop = do_core;

    always_comb begin
        inflight_miss = 1'b0;
        fill_match_st3 = fill_valid && (fill_addr == addr_q[pipe_ctrl_pkg::PIPE_DEPTH]);
        for (int k = 1; k <= pipe_ctrl_pkg::PIPE_DEPTH; k++) begin
            // a miss ahead of us will already request this line
            if (v_q[k] && !fill_q[k] && !stage_hit[k] && (addr_q[k] == addr_st0)) begin
                inflight_miss = 1'b1;
            end
            // fills younger than the st3 item came after its lookup
            if ((k < pipe_ctrl_pkg::PIPE_DEPTH) && v_q[k] && fill_q[k] &&
                (addr_q[k] == addr_q[pipe_ctrl_pkg::PIPE_DEPTH])) begin
                fill_match_st3 = 1'b1;
            end
        end
    end

    assign hazard_st0 = do_core && (pending_hazard_st0 || inflight_miss);

    assign at_st3 = v_q[pipe_ctrl_pkg::PIPE_DEPTH] && !fill_q[pipe_ctrl_pkg::PIPE_DEPTH];
    assign enqueue_st3 = at_st3 && !hit_q[pipe_ctrl_pkg::PIPE_DEPTH];
    assign enqueue_addr_st3 = addr_q[pipe_ctrl_pkg::PIPE_DEPTH];
    assign enqueue_tag_st3 = tag_q[pipe_ctrl_pkg::PIPE_DEPTH];
    assign enqueue_msrq_st3 = rpl_q[pipe_ctrl_pkg::PIPE_DEPTH];
    assign enqueue_ready_st3 = fill_match_st3;
    assign dequeue_st3 = at_st3 && rpl_q[pipe_ctrl_pkg::PIPE_DEPTH] &&
                         hit_q[pipe_ctrl_pkg::PIPE_DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            v_q <= '0;
            fill_q <= '0;
            rpl_q <= '0;
            mem_req_valid <= 1'b0;
            core_rsp_valid <= 1'b0;
        end else begin
            v_q <= {v_q[pipe_ctrl_pkg::PIPE_DEPTH-1:1], issue_st0};
            fill_q <= {fill_q[pipe_ctrl_pkg::PIPE_DEPTH-1:1], fill_valid};
            rpl_q <= {rpl_q[pipe_ctrl_pkg::PIPE_DEPTH-1:1], do_replay};
            core_rsp_valid <= at_st3 && hit_q[pipe_ctrl_pkg::PIPE_DEPTH];
            mem_req_valid <= enqueue_st3 && !haz_q[pipe_ctrl_pkg::PIPE_DEPTH] &&
                             !fill_match_st3;
        end
    end

    always_ff @(posedge clk) begin
        addr_q[1] <= addr_st0;
        tag_q[1] <= tag_st0;
        for (int k = 2; k <= pipe_ctrl_pkg::PIPE_DEPTH; k++) begin
            addr_q[k] <= addr_q[k-1];
            tag_q[k] <= tag_q[k-1];
        end
        haz_q <= {haz_q[pipe_ctrl_pkg::PIPE_DEPTH-1:1], hazard_st0};
        hit_q <= stage_hit[pipe_ctrl_pkg::PIPE_DEPTH-1:1];
        mem_req_addr <= addr_q[pipe_ctrl_pkg::PIPE_DEPTH];
        core_rsp_tag <= tag_q[pipe_ctrl_pkg::PIPE_DEPTH];
        core_rsp_addr <= addr_q[pipe_ctrl_pkg::PIPE_DEPTH];
    end

    // a fill taken at st0 never comes out as a response
    assert property (@(posedge clk) disable iff (reset)
        $past(fill_valid, pipe_ctrl_pkg::PIPE_DEPTH + 1) |-> !core_rsp_valid);

endmodule

`default_nettype wire

//--- logic/miss_path_top.sv
`timescale 1ns/100ps
`default_nettype none

module miss_path_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       core_req_valid,
    input  cache_geom_pkg::line_addr_t core_req_addr,
    input  cache_geom_pkg::req_tag_t   core_req_tag,
    output logic                       core_req_full,
    input  logic                       fill_valid,
    input  cache_geom_pkg::line_addr_t fill_addr,
    output logic                       mem_req_valid,
    output cache_geom_pkg::line_addr_t mem_req_addr,
    output logic                       core_rsp_valid,
    output cache_geom_pkg::req_tag_t   core_rsp_tag,
    output cache_geom_pkg::line_addr_t core_rsp_addr
);

    logic                       fifo_valid;
    cache_geom_pkg::line_addr_t fifo_addr;
    cache_geom_pkg::req_tag_t   fifo_tag;
    logic                       fifo_pop;
    cache_geom_pkg::line_addr_t lookup_addr;
    logic                       lookup_hit;
    cache_geom_pkg::line_addr_t addr_st0;
    logic                       update_ready_st0;
    logic                       pending_hazard_st0;
    logic                       schedule_st0;
    logic                       dequeue_valid_st0;
    cache_geom_pkg::line_addr_t dequeue_addr_st0;
    cache_geom_pkg::req_tag_t   dequeue_tag_st0;
    logic                       enqueue_st3;
    cache_geom_pkg::line_addr_t enqueue_addr_st3;
    cache_geom_pkg::req_tag_t   enqueue_tag_st3;
    logic                       enqueue_msrq_st3;
    logic                       enqueue_ready_st3;
    logic                       enqueue_almfull;
    logic                       dequeue_st3;

    core_req_fifo #(
        .DEPTH(pipe_ctrl_pkg::REQ_FIFO_DEPTH)
    ) req_fifo (
        .clk(clk),
        .reset(reset),
        .push(core_req_valid),
        .push_addr(core_req_addr),
        .push_tag(core_req_tag),
        .pop(fifo_pop),
        .head_valid(fifo_valid),
        .head_addr(fifo_addr),
        .head_tag(fifo_tag),
        .full(core_req_full)
    );

    line_state_table state_table (
        .clk(clk),
        .reset(reset),
        .lookup_addr(lookup_addr),
        .fill_valid(fill_valid),
        .fill_addr(fill_addr),
        .lookup_hit(lookup_hit)
    );

    miss_resrv_queue mrvq (
        .clk(clk),
        .reset(reset),
        .enqueue_st3(enqueue_st3),
        .enqueue_addr_st3(enqueue_addr_st3),
        .enqueue_tag_st3(enqueue_tag_st3),
        .enqueue_msrq_st3(enqueue_msrq_st3),
        .enqueue_ready_st3(enqueue_ready_st3),
        .enqueue_full(),
        .enqueue_almfull(enqueue_almfull),
        .update_ready_st0(update_ready_st0),
        .addr_st0(addr_st0),
        .pending_hazard_st0(pending_hazard_st0),
        .schedule_st0(schedule_st0),
        .dequeue_valid_st0(dequeue_valid_st0),
        .dequeue_addr_st0(dequeue_addr_st0),
        .dequeue_tag_st0(dequeue_tag_st0),
        .dequeue_st3(dequeue_st3)
    );

    bank_pipeline pipe (
        .clk(clk),
        .reset(reset),
        .fifo_valid(fifo_valid),
        .fifo_addr(fifo_addr),
        .fifo_tag(fifo_tag),
        .fifo_pop(fifo_pop),
        .fill_valid(fill_valid),
        .fill_addr(fill_addr),
        .lookup_addr(lookup_addr),
        .lookup_hit(lookup_hit),
        .addr_st0(addr_st0),
        .update_ready_st0(update_ready_st0),
        .pending_hazard_st0(pending_hazard_st0),
        .dequeue_valid_st0(dequeue_valid_st0),
        .dequeue_addr_st0(dequeue_addr_st0),
        .dequeue_tag_st0(dequeue_tag_st0),
        .schedule_st0(schedule_st0),
        .enqueue_almfull(enqueue_almfull),
        .enqueue_st3(enqueue_st3),
        .enqueue_addr_st3(enqueue_addr_st3),
        .enqueue_tag_st3(enqueue_tag_st3),
        .enqueue_msrq_st3(enqueue_msrq_st3),
        .enqueue_ready_st3(enqueue_ready_st3),
        .dequeue_st3(dequeue_st3),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr(mem_req_addr),
        .core_rsp_valid(core_rsp_valid),
        .core_rsp_tag(core_rsp_tag),
        .core_rsp_addr(core_rsp_addr)
    );

endmodule

`default_nettype wire

//--- bench/miss_path_tb.sv
`timescale 1ns/100ps
`default_nettype none

module miss_path_tb;

    logic                       clk;
    logic                       reset;
    logic                       core_req_valid;
    cache_geom_pkg::line_addr_t core_req_addr;
    cache_geom_pkg::req_tag_t   core_req_tag;
    logic                       core_req_full;
    logic                       fill_valid;
    cache_geom_pkg::line_addr_t fill_addr;
    logic                       mem_req_valid;
    cache_geom_pkg::line_addr_t mem_req_addr;
    logic                       core_rsp_valid;
    cache_geom_pkg::req_tag_t   core_rsp_tag;
    cache_geom_pkg::line_addr_t core_rsp_addr;

    // reference table, one line per set
    logic                      model_valid [cache_geom_pkg::NUM_SETS];
    cache_geom_pkg::line_tag_t model_tag [cache_geom_pkg::NUM_SETS];
    int last_fill [1 << cache_geom_pkg::LINE_ADDR_BITS];
    bit outstanding [1 << cache_geom_pkg::LINE_ADDR_BITS];

    // open requests, indexed by core tag
    bit                         tag_open [1 << cache_geom_pkg::REQ_TAG_BITS];
    bit                         tag_hit [1 << cache_geom_pkg::REQ_TAG_BITS];
    int                         tag_cycle [1 << cache_geom_pkg::REQ_TAG_BITS];
    cache_geom_pkg::line_addr_t tag_addr [1 << cache_geom_pkg::REQ_TAG_BITS];
    cache_geom_pkg::req_tag_t   hit_order [$];

    cache_geom_pkg::line_addr_t fill_line_q [$];
    int fill_due_q [$];

    int rec_kind [$];
    int rec_test [$];
    int rec_a [$];
    int rec_b [$];
    int rec_c [$];
    int rec_d [$];

    int cycle = 0;
    int cycle_limit = 0;
    int num_requests = 0;
    int seed = 32261;
    int open_count = 0;
    int rsp_count = 0;
    int mem_count = 0;
    bit full_seen = 1'b0;
    bit req_seen = 1'b0;

    miss_path_top dut (
        .clk(clk),
        .reset(reset),
        .core_req_valid(core_req_valid),
        .core_req_addr(core_req_addr),
        .core_req_tag(core_req_tag),
        .core_req_full(core_req_full),
        .fill_valid(fill_valid),
        .fill_addr(fill_addr),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr(mem_req_addr),
        .core_rsp_valid(core_rsp_valid),
        .core_rsp_tag(core_rsp_tag),
        .core_rsp_addr(core_rsp_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_tag(input string name, input cache_geom_pkg::req_tag_t got,
                             input cache_geom_pkg::req_tag_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input cache_geom_pkg::line_addr_t got,
                              input cache_geom_pkg::line_addr_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic bit line_present(input cache_geom_pkg::line_addr_t a);
        cache_geom_pkg::set_idx_t s;
        s = a[cache_geom_pkg::SET_BITS-1:0];
        return model_valid[s] &&
               (model_tag[s] == a[cache_geom_pkg::LINE_ADDR_BITS-1:cache_geom_pkg::SET_BITS]);
    endfunction

    function automatic int next_due_fill();
        int best;
        best = -1;
        for (int i = 0; i < fill_due_q.size(); i++) begin
            if (fill_due_q[i] <= cycle && (best < 0 || fill_due_q[i] < fill_due_q[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic load_stimulus();
        int fd;
        int t;
        int a;
        int b;
        int c;
        int d;
        string line;
        fd = $fopen("bench/miss_path_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file bench/miss_path_input.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "R %d %d %h %h", t, a, b, c) == 4) begin
                rec_kind.push_back(0);
                d = 0;
                num_requests++;
            end else if ($sscanf(line, "E %d %d %d %d %d", t, a, b, c, d) == 5) begin
                rec_kind.push_back(1);
            end else begin
                continue;
            end
            rec_test.push_back(t);
            rec_a.push_back(a);
            rec_b.push_back(b);
            rec_c.push_back(c);
            rec_d.push_back(d);
        end
        $fclose(fd);
    endtask

    task automatic send_request(input int gap, input int addr, input int tag);
        cache_geom_pkg::line_addr_t a;
        cache_geom_pkg::req_tag_t t;
        a = cache_geom_pkg::line_addr_t'(addr);
        t = cache_geom_pkg::req_tag_t'(tag);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        // buffer full, hold the request back
        while (core_req_full) begin
            @(posedge clk);
            #1;
        end
        if (tag_open[t]) begin
            $display("stimulus reuses tag %h while it is still open", t);
            abort_run();
        end
        tag_open[t] = 1'b1;
        tag_addr[t] = a;
        tag_cycle[t] = cycle;
        tag_hit[t] = line_present(a);
        if (tag_hit[t]) begin
            hit_order.push_back(t);
        end
        open_count++;
        req_seen = 1'b1;
        core_req_valid = 1'b1;
        core_req_addr = a;
        core_req_tag = t;
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
    endtask

    task automatic close_test(input int test, input int rsp, input int mem,
                              input int mem_fixed, input int full_exp);
        while (open_count != 0 || fill_due_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        check_count("core_rsp_valid count", rsp_count, rsp);
        if (mem_fixed != 0) begin
            check_count("mem_req_valid count", mem_count, mem);
        end
        if (full_exp != 0 && !full_seen) begin
            $display("core_req_full never rose during test %0d", test);
            abort_run();
        end
        $display("test %0d done: %0d responses, %0d memory requests", test, rsp_count, mem_count);
        rsp_count = 0;
        mem_count = 0;
        full_seen = 1'b0;
    endtask

    task automatic handle_mem_req();
        int r;
        int delay;
        bit wanted;
        wanted = 1'b0;
        // only a line that an open request still waits for may be fetched
        for (int i = 0; i < (1 << cache_geom_pkg::REQ_TAG_BITS); i++) begin
            if (tag_open[i] && tag_addr[i] == mem_req_addr) begin
                wanted = 1'b1;
            end
        end
        if (!wanted) begin
            $display("memory request for line %h with no open request for it",
                     mem_req_addr);
            abort_run();
        end
        if (outstanding[mem_req_addr]) begin
            $display("second memory request for line %h while it is still pending", mem_req_addr);
            abort_run();
        end
        outstanding[mem_req_addr] = 1'b1;
        mem_count++;
        r = $random(seed);
        delay = 6 + int'($unsigned(r) % 15);
        fill_line_q.push_back(mem_req_addr);
        fill_due_q.push_back(cycle + delay);
    endtask

    task automatic handle_response();
        cache_geom_pkg::req_tag_t t;
        cache_geom_pkg::line_addr_t a;
        cache_geom_pkg::req_tag_t first_hit;
        t = core_rsp_tag;
        a = core_rsp_addr;
        if (!tag_open[t]) begin
            $display("response with tag %h that has no open request", t);
            abort_run();
        end
        check_line("core_rsp_addr", a, tag_addr[t]);
        if (last_fill[a] < 0) begin
            $display("response names line %h which was never filled", a);
            abort_run();
        end
        if (!tag_hit[t] && last_fill[a] < tag_cycle[t]) begin
            $display("tag %h answered before the fill of line %h", t, a);
            abort_run();
        end
        if (cycle - tag_cycle[t] < 5) begin
            $display("tag %h answered %0d cycles after its request", t, cycle - tag_cycle[t]);
            abort_run();
        end
        // predicted hits leave the pipeline in request order
        if (tag_hit[t]) begin
            first_hit = hit_order.pop_front();
            check_tag("core_rsp_tag", t, first_hit);
        end
        tag_open[t] = 1'b0;
        open_count--;
        rsp_count++;
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle_limit != 0 && cycle > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // outputs are registered, sample them mid-cycle
    always @(negedge clk) begin
        if (core_req_full) begin
            full_seen = 1'b1;
        end
        if (reset || !req_seen) begin
            if (core_rsp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
                $display("response or memory request during reset or before any request");
                abort_run();
            end
        end else begin
            if (mem_req_valid) begin
                handle_mem_req();
            end
            if (core_rsp_valid) begin
                handle_response();
            end
        end
    end

    // memory model, at most one fill per cycle
    initial begin : memory_model
        int idx;
        cache_geom_pkg::line_addr_t a;
        fill_valid = 1'b0;
        fill_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            fill_valid = 1'b0;
            idx = next_due_fill();
            if (idx >= 0) begin
                a = fill_line_q[idx];
                fill_line_q.delete(idx);
                fill_due_q.delete(idx);
                fill_valid = 1'b1;
                fill_addr = a;
                model_valid[a[cache_geom_pkg::SET_BITS-1:0]] = 1'b1;
                model_tag[a[cache_geom_pkg::SET_BITS-1:0]] =
                    a[cache_geom_pkg::LINE_ADDR_BITS-1:cache_geom_pkg::SET_BITS];
                last_fill[a] = cycle;
                outstanding[a] = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int i;
        reset = 1'b1;
        core_req_valid = 1'b0;
        core_req_addr = '0;
        core_req_tag = '0;
        for (i = 0; i < cache_geom_pkg::NUM_SETS; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = '0;
        end
        for (i = 0; i < (1 << cache_geom_pkg::LINE_ADDR_BITS); i++) begin
            last_fill[i] = -1;
        end
        load_stimulus();
        cycle_limit = 40 * num_requests + 200;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (i = 0; i < rec_kind.size(); i++) begin
            if (rec_kind[i] == 0) begin
                send_request(rec_a[i], rec_b[i], rec_c[i]);
            end else begin
                close_test(rec_test[i], rec_a[i], rec_b[i], rec_c[i], rec_d[i]);
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/miss_path_input.txt
# R test gap_cycles line_addr_hex tag_hex
# E test responses mem_requests mem_count_checked full_expected
R 1 0 011 01
R 1 40 011 02
R 1 0 011 03
R 1 0 011 04
E 1 4 1 1 0
R 2 0 032 05
R 2 0 043 06
R 2 0 054 07
R 2 1 065 08
E 2 4 4 1 0
R 3 0 077 09
R 3 0 077 0a
R 3 0 077 0b
R 3 1 077 0c
R 3 0 077 0d
E 3 5 1 1 0
R 4 0 108 0e
R 4 0 208 0f
R 4 0 108 10
R 4 0 208 11
E 4 4 0 0 0
R 5 0 2a0 12
R 5 0 2a1 13
R 5 0 2a2 14
R 5 0 2a3 15
R 5 0 2a4 16
R 5 0 2a5 17
R 5 0 2a6 18
R 5 0 2a7 19
R 5 0 2a9 1a
R 5 0 2aa 1b
R 5 0 2ab 1c
R 5 0 2ac 1d
R 5 0 2ad 1e
R 5 0 2ae 1f
E 5 14 14 1 1

//--- tb.f
logic/cache_geom_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/core_req_fifo.sv
logic/line_state_table.sv
logic/miss_resrv_queue.sv
logic/bank_pipeline.sv
logic/miss_path_top.sv
bench/miss_path_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module miss_path_tb -o Vmiss_path_tb

./obj_dir/Vmiss_path_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
